//--- tqv_settings.svh
// Sizes for the RV32E-style register file and the APB port; address is byte-exact, data is 32 bits
`ifndef TQV_SETTINGS_SVH
`define TQV_SETTINGS_SVH

`define TQV_NUM_REGS      16   // x0..x15 as in RV32E
`define TQV_REG_ADDR_BITS 4

`define TQV_ADDR_BITS     28   // APB byte address
`define TQV_DATA_BITS     32
`define TQV_PC_BITS       24

`endif

//--- tqv_pkg.sv
// Shared types; widths come from the settings header, instructions arrive already decoded
`default_nettype none

`include "tqv_settings.svh"

package tqv_pkg;

    typedef enum logic [3:0] {
        NOP, LOAD, STORE, ALU_IMM, ALU_REG, LUI, AUIPC, BRANCH, JAL, JALR, SYSTEM
    } instr_kind_e;

    // {funct7[5], funct3} style code
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    typedef logic [2:0] mem_op_t;  // funct3 of load, store or branch

    typedef struct packed {
        instr_kind_e                   kind;
        alu_op_e                       alu_op;
        mem_op_t                       mem_op;
        logic [`TQV_REG_ADDR_BITS-1:0] rs1;
        logic [`TQV_REG_ADDR_BITS-1:0] rs2;
        logic [`TQV_REG_ADDR_BITS-1:0] rd;
        logic [31:0]                   imm;
        logic [`TQV_PC_BITS-1:0]       pc;
        logic [`TQV_PC_BITS-1:0]       next_pc;
    } decoded_instr_t;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`TQV_ADDR_BITS-1:0] paddr;
        logic [`TQV_DATA_BITS-1:0] pwdata;
        logic [3:0]                pstrb;
    } apb_req_t;

    typedef struct packed {
        logic                      pready;
        logic [`TQV_DATA_BITS-1:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic                      valid;
        logic                      write;
        mem_op_t                   mem_op;
        logic [`TQV_ADDR_BITS-1:0] addr;
        logic [`TQV_DATA_BITS-1:0] wdata;  // Raw rs2, lane placement is done in the LSU
    } mem_cmd_t;

endpackage

`default_nettype wire

//--- tqv_alu.sv
// Purely combinational; result covers ADD/SUB/logic ops, cmp is equality unless op is SLT/SLTU
`default_nettype none

`include "tqv_settings.svh"

module tqv_alu (
    input  wire tqv_pkg::alu_op_e     op,
    input  wire [`TQV_DATA_BITS-1:0]  a,
    input  wire [`TQV_DATA_BITS-1:0]  b,
    output logic [`TQV_DATA_BITS-1:0] result,
    output logic                      cmp
);

    logic [`TQV_DATA_BITS:0] diff;
    logic                    lt_u;
    logic                    lt_s;

    assign diff = {1'b0, a} - {1'b0, b};
    assign lt_u = diff[`TQV_DATA_BITS];  // Borrow out

    // Signs differ: a is smaller when negative
    assign lt_s = (a[`TQV_DATA_BITS-1] ^ b[`TQV_DATA_BITS-1]) ? a[`TQV_DATA_BITS-1] : lt_u;

    always_comb begin
        case (op)
            tqv_pkg::ALU_SUB: result = diff[`TQV_DATA_BITS-1:0];
            tqv_pkg::ALU_XOR: result = a ^ b;
            tqv_pkg::ALU_OR:  result = a | b;
            tqv_pkg::ALU_AND: result = a & b;
            default:          result = a + b;  // ADD, also address and target sums
        endcase
    end

    always_comb begin
        if (op[3:1] == 3'b001)
            cmp = op[0] ? lt_u : lt_s;
        else
            cmp = a == b;
    end

endmodule

`default_nettype wire

//--- tqv_shifter.sv
// 32-bit barrel shifter; dir_arith is alu_op[3:2], so 00 left, 01 logical right, 11 arithmetic
`default_nettype none

module tqv_shifter (
    input  wire [1:0]  dir_arith,
    input  wire [31:0] data,
    input  wire [4:0]  amount,
    output logic [31:0] result
);

    logic        fill;
    logic [32:0] right_in;
    logic [32:0] right_out;

    assign fill      = dir_arith[1] & data[31];  // Sign bit only for SRA
    assign right_in  = {fill, data};
    assign right_out = $signed(right_in) >>> amount;

    always_comb begin
        if (dir_arith[0])
            result = right_out[31:0];
        else
            result = data << amount;
    end

endmodule

`default_nettype wire

//--- tqv_registers.sv
// Register file with combinational reads; x0 reads zero and ignores writes, all cleared on reset
`default_nettype none

`include "tqv_settings.svh"

module tqv_registers (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          wr_en,
    input  wire [`TQV_REG_ADDR_BITS-1:0] rs1,
    input  wire [`TQV_REG_ADDR_BITS-1:0] rs2,
    input  wire [`TQV_REG_ADDR_BITS-1:0] rd,
    input  wire [`TQV_DATA_BITS-1:0]     wr_data,
    output logic [`TQV_DATA_BITS-1:0]    rs1_data,
    output logic [`TQV_DATA_BITS-1:0]    rs2_data
);

    logic [`TQV_DATA_BITS-1:0] regs [`TQV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `TQV_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- tqv_lsu_apb.sv
// Single-transfer APB master; cmd must hold until done, word reads assume an aligned address
`default_nettype none

`include "tqv_settings.svh"

module tqv_lsu_apb (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire tqv_pkg::mem_cmd_t     cmd,
    input  wire tqv_pkg::apb_rsp_t     rsp,
    output tqv_pkg::apb_req_t          req,
    output logic                       done,
    output logic [`TQV_DATA_BITS-1:0]  load_data
);

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_e;

    state_e                    state;
    logic [`TQV_ADDR_BITS-1:0] paddr_q;
    logic                      pwrite_q;
    logic [`TQV_DATA_BITS-1:0] pwdata_q;
    logic [3:0]                pstrb_q;
    tqv_pkg::mem_op_t          mem_op_q;
    logic [`TQV_DATA_BITS-1:0] rdata_q;
    logic [`TQV_DATA_BITS-1:0] lane_wdata;
    logic [3:0]                lane_strb;
    logic [`TQV_DATA_BITS-1:0] rdata_shifted;

    // Store data replicated across lanes, strobe picks the addressed one
    always_comb begin
        case (cmd.mem_op[1:0])
            2'b00: begin
                lane_strb  = 4'b0001 << cmd.addr[1:0];
                lane_wdata = {4{cmd.wdata[7:0]}};
            end
            2'b01: begin
                lane_strb  = 4'b0011 << {cmd.addr[1], 1'b0};
                lane_wdata = {2{cmd.wdata[15:0]}};
            end
            default: begin
                lane_strb  = 4'b1111;
                lane_wdata = cmd.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE:    if (cmd.valid) state <= SETUP;
                SETUP:   state <= ACCESS;
                ACCESS: begin
                    if (rsp.pready) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields latched once so they hold through wait states
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd.valid) begin
            paddr_q  <= cmd.addr;
            pwrite_q <= cmd.write;
            pwdata_q <= lane_wdata;
            pstrb_q  <= lane_strb;
            mem_op_q <= cmd.mem_op;
        end
        if (state == ACCESS && rsp.pready) rdata_q <= rsp.prdata;
    end

    always_comb begin
        req.psel    = state != IDLE;
        req.penable = state == ACCESS;
        req.pwrite  = pwrite_q;
        req.paddr   = paddr_q;
        req.pwdata  = pwdata_q;
        req.pstrb   = pwrite_q ? pstrb_q : 4'b0000;  // No strobes on reads
    end

    assign rdata_shifted = rdata_q >> {paddr_q[1:0], 3'b000};

    always_comb begin
        case (mem_op_q[1:0])
            2'b00:   load_data = {{24{~mem_op_q[2] & rdata_shifted[7]}}, rdata_shifted[7:0]};
            2'b01:   load_data = {{16{~mem_op_q[2] & rdata_shifted[15]}}, rdata_shifted[15:0]};
            default: load_data = rdata_shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- tqv_core.sv
// Instruction must be held stable until instr_complete; one memory access at a time, no traps
`default_nettype none

`include "tqv_settings.svh"

module tqv_core (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire tqv_pkg::decoded_instr_t instr,
    input  wire [`TQV_DATA_BITS-1:0]     rs1_data,
    input  wire [`TQV_DATA_BITS-1:0]     rs2_data,
    input  wire [`TQV_DATA_BITS-1:0]     alu_result,
    input  wire                          alu_cmp,
    input  wire [`TQV_DATA_BITS-1:0]     shift_out,
    input  wire                          mem_done,
    input  wire [`TQV_DATA_BITS-1:0]     load_data,
    output logic                         rd_wr_en,
    output logic [`TQV_DATA_BITS-1:0]    rd_data,
    output tqv_pkg::alu_op_e             alu_op,
    output logic [`TQV_DATA_BITS-1:0]    alu_a,
    output logic [`TQV_DATA_BITS-1:0]    alu_b,
    output logic [4:0]                   shift_amt,
    output tqv_pkg::mem_cmd_t            mem_cmd,
    output logic                         instr_complete,
    output logic                         branch,
    output logic [`TQV_PC_BITS-1:0]      branch_addr
);

    logic [1:0]                cycle;
    logic                      is_mem;
    logic                      is_alu;
    logic                      is_link;
    logic                      is_slt;
    logic                      is_shift;
    logic [`TQV_DATA_BITS-1:0] pc_ext;
    logic [`TQV_DATA_BITS-1:0] next_pc_ext;

    assign is_mem   = instr.kind == tqv_pkg::LOAD || instr.kind == tqv_pkg::STORE;
    assign is_alu   = instr.kind == tqv_pkg::ALU_IMM || instr.kind == tqv_pkg::ALU_REG;
    assign is_link  = instr.kind == tqv_pkg::JAL || instr.kind == tqv_pkg::JALR;
    assign is_slt   = instr.alu_op[3:1] == 3'b001;
    assign is_shift = instr.alu_op[1:0] == 2'b01;

    assign pc_ext      = {{(`TQV_DATA_BITS-`TQV_PC_BITS){1'b0}}, instr.pc};
    assign next_pc_ext = {{(`TQV_DATA_BITS-`TQV_PC_BITS){1'b0}}, instr.next_pc};

    // Branches pick their compare from funct3, everything else non-ALU needs a sum
    always_comb begin
        if (instr.kind == tqv_pkg::BRANCH) begin
            if (!instr.mem_op[2])
                alu_op = tqv_pkg::ALU_SUB;  // BEQ/BNE use the equality flag
            else if (instr.mem_op[1])
                alu_op = tqv_pkg::ALU_SLTU;
            else
                alu_op = tqv_pkg::ALU_SLT;
        end else if (is_alu) begin
            alu_op = instr.alu_op;
        end else begin
            alu_op = tqv_pkg::ALU_ADD;
        end
    end

    assign alu_a = (instr.kind == tqv_pkg::AUIPC || instr.kind == tqv_pkg::JAL) ? pc_ext : rs1_data;
    assign alu_b = (instr.kind == tqv_pkg::ALU_REG || instr.kind == tqv_pkg::BRANCH) ?
                   rs2_data : instr.imm;
    assign shift_amt = (instr.kind == tqv_pkg::ALU_IMM) ? instr.imm[4:0] : rs2_data[4:0];

    always_comb begin
        rd_wr_en = 1'b0;
        rd_data  = alu_result;
        case (instr.kind)
            tqv_pkg::ALU_IMM, tqv_pkg::ALU_REG: begin
                rd_wr_en = 1'b1;
                if (is_slt)
                    rd_data = {{(`TQV_DATA_BITS-1){1'b0}}, alu_cmp};
                else if (is_shift)
                    rd_data = shift_out;
            end
            tqv_pkg::AUIPC: rd_wr_en = 1'b1;
            tqv_pkg::LUI: begin
                rd_wr_en = 1'b1;
                rd_data  = instr.imm;
            end
            tqv_pkg::JAL, tqv_pkg::JALR: begin
                rd_wr_en = 1'b1;
                rd_data  = next_pc_ext;  // Link value
            end
            tqv_pkg::LOAD: begin
                rd_wr_en = mem_done;
                rd_data  = load_data;
            end
            default: rd_wr_en = 1'b0;
        endcase
        if (cycle == 2'd0 && !is_mem) rd_wr_en = 1'b0;  // Operands settle in cycle 0
    end

    always_comb begin
        mem_cmd.valid  = is_mem && !mem_done;  // Drop in the done cycle so the LSU stays idle
        mem_cmd.write  = instr.kind == tqv_pkg::STORE;
        mem_cmd.mem_op = instr.mem_op;
        mem_cmd.addr   = alu_result[`TQV_ADDR_BITS-1:0];
        mem_cmd.wdata  = rs2_data;
    end

    assign branch = (is_link && cycle == 2'd1) ||
                    (instr.kind == tqv_pkg::BRANCH && (alu_cmp ^ instr.mem_op[0]));
    assign branch_addr = (instr.kind == tqv_pkg::BRANCH) ?
                         instr.pc + instr.imm[`TQV_PC_BITS-1:0] : alu_result[`TQV_PC_BITS-1:0];

    always_comb begin
        case (instr.kind)
            tqv_pkg::LOAD, tqv_pkg::STORE: instr_complete = mem_done;
            tqv_pkg::ALU_IMM, tqv_pkg::ALU_REG, tqv_pkg::LUI, tqv_pkg::AUIPC,
            tqv_pkg::JAL, tqv_pkg::JALR:   instr_complete = cycle == 2'd1;
            default:                       instr_complete = 1'b1;  // NOP, BRANCH, SYSTEM
        endcase
    end

    // Saturates at 3 while a memory access waits
    always_ff @(posedge clk) begin
        if (!rstn)
            cycle <= 2'd0;
        else if (instr_complete)
            cycle <= 2'd0;
        else if (cycle != 2'd3)
            cycle <= cycle + 2'd1;
    end

endmodule

`default_nettype wire

//--- tqv_exec_top.sv
// Execute stage top; instr comes from an external decoder and must hold until instr_complete
`default_nettype none

`include "tqv_settings.svh"

module tqv_exec_top (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire tqv_pkg::decoded_instr_t instr,
    output logic                         instr_complete,
    output logic                         branch,
    output logic [`TQV_PC_BITS-1:0]      branch_addr,
    output tqv_pkg::apb_req_t            apb_req,
    input  wire tqv_pkg::apb_rsp_t       apb_rsp
);

    logic [`TQV_DATA_BITS-1:0] rs1_data;
    logic [`TQV_DATA_BITS-1:0] rs2_data;
    logic [`TQV_DATA_BITS-1:0] rd_data;
    logic [`TQV_DATA_BITS-1:0] alu_a;
    logic [`TQV_DATA_BITS-1:0] alu_b;
    logic [`TQV_DATA_BITS-1:0] alu_result;
    logic [`TQV_DATA_BITS-1:0] shift_out;
    logic [`TQV_DATA_BITS-1:0] load_data;
    logic                      rd_wr_en;
    logic                      alu_cmp;
    logic                      mem_done;
    logic [4:0]                shift_amt;
    tqv_pkg::alu_op_e          alu_op;
    tqv_pkg::mem_cmd_t         mem_cmd;

    tqv_core i_core (
        .clk, .rstn, .instr, .rs1_data, .rs2_data, .alu_result, .alu_cmp, .shift_out,
        .mem_done, .load_data, .rd_wr_en, .rd_data, .alu_op, .alu_a, .alu_b, .shift_amt,
        .mem_cmd, .instr_complete, .branch, .branch_addr
    );

    tqv_registers i_registers (
        .clk, .rstn, .wr_en(rd_wr_en), .rs1(instr.rs1), .rs2(instr.rs2), .rd(instr.rd),
        .wr_data(rd_data), .rs1_data, .rs2_data
    );

    tqv_alu i_alu (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .cmp(alu_cmp));

    tqv_shifter i_shifter (
        .dir_arith(alu_op[3:2]), .data(rs1_data), .amount(shift_amt), .result(shift_out)
    );

    tqv_lsu_apb i_lsu (
        .clk, .rstn, .cmd(mem_cmd), .rsp(apb_rsp), .req(apb_req), .done(mem_done), .load_data
    );

endmodule

`default_nettype wire

//--- tb_tqv_exec.sv
// Self-checking testbench; 64-word APB memory with random wait states, watchdog bounds the run
`default_nettype none

`include "tqv_settings.svh"

module tb_tqv_exec;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 5;

    logic                          clk;
    logic                          rstn;
    tqv_pkg::decoded_instr_t       instr;
    logic                          instr_complete;
    logic                          branch;
    logic [`TQV_PC_BITS-1:0]       branch_addr;
    tqv_pkg::apb_req_t             apb_req;
    tqv_pkg::apb_rsp_t             apb_rsp = '0;

    logic [31:0]             mem [64];                // APB slave storage
    logic [31:0]             ref_mem [64];            // Expected memory image
    logic [31:0]             ref_regs [`TQV_NUM_REGS];
    logic [`TQV_PC_BITS-1:0] cur_pc;
    int                      errors = 0;
    int                      checks = 0;
    int                      tests_run = 0;
    int                      test_err_base = 0;
    tqv_pkg::alu_op_e        ops [10] = '{tqv_pkg::ALU_ADD, tqv_pkg::ALU_SUB, tqv_pkg::ALU_XOR,
        tqv_pkg::ALU_OR, tqv_pkg::ALU_AND, tqv_pkg::ALU_SLT, tqv_pkg::ALU_SLTU,
        tqv_pkg::ALU_SLL, tqv_pkg::ALU_SRL, tqv_pkg::ALU_SRA};

    tqv_exec_top i_tqv_exec_top (
        .clk, .rstn, .instr, .instr_complete, .branch, .branch_addr, .apb_req, .apb_rsp
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles", NUM_TESTS * 200);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Every byte depends on the full word index, top and bottom bytes are negative
    function automatic logic [31:0] fill_word(input int i);
        return {8'(i) | 8'h80, 8'(i) ^ 8'h5a, 8'(i * 3 + 1), ~8'(i)};
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    function automatic logic [31:0] alu_expect(input tqv_pkg::alu_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
        case (op)
            tqv_pkg::ALU_SUB:  return a - b;
            tqv_pkg::ALU_XOR:  return a ^ b;
            tqv_pkg::ALU_OR:   return a | b;
            tqv_pkg::ALU_AND:  return a & b;
            tqv_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            tqv_pkg::ALU_SLTU: return {31'b0, a < b};
            tqv_pkg::ALU_SLL:  return a << b[4:0];
            tqv_pkg::ALU_SRL:  return a >> b[4:0];
            tqv_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            default:           return a + b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] load_expect(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] sh;
        sh = ref_mem[addr[7:2]] >> {addr[1:0], 3'b000};
        case (f3[1:0])
            2'b00:   return f3[2] ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            2'b01:   return f3[2] ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    task automatic note_failure(input string what);
        $display("Failure at %0d ns: %s", $time, what);
        errors++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, name, got,
                     expected);
            errors++;
        end
    endtask

    // Apply one decoded instruction, check it cycle by cycle, then update the model
    task automatic exec(input tqv_pkg::instr_kind_e kind, input tqv_pkg::alu_op_e op,
                        input logic [2:0] f3, input int rs1, input int rs2, input int rd,
                        input logic [31:0] imm);
        tqv_pkg::decoded_instr_t d;
        logic [31:0]             a;
        logic [31:0]             b;
        logic [31:0]             rs2v;
        logic [31:0]             res;
        logic [31:0]             addr;
        logic [31:0]             wdata;
        logic [3:0]              strb;
        logic [`TQV_PC_BITS-1:0] target;
        logic                    exp_br;
        logic                    writes;
        logic                    is_mem;
        logic                    finished;
        int                      clocks;
        int                      want;
        d = '{kind, op, f3, 4'(rs1), 4'(rs2), 4'(rd), imm, cur_pc, cur_pc + 24'd4};
        a = (kind == tqv_pkg::AUIPC || kind == tqv_pkg::JAL) ? {8'h00, cur_pc} : ref_regs[rs1];
        rs2v = ref_regs[rs2];
        b = (kind == tqv_pkg::ALU_REG || kind == tqv_pkg::BRANCH) ? rs2v : imm;
        addr = a + imm;
        is_mem = kind == tqv_pkg::LOAD || kind == tqv_pkg::STORE;
        res = alu_expect(op, a, b);
        writes = 1'b1;
        exp_br = 1'b0;
        target = '0;
        want = 2;
        case (f3[1:0])
            2'b00: begin
                strb  = 4'b0001 << addr[1:0];
                wdata = {4{rs2v[7:0]}};
            end
            2'b01: begin
                strb  = 4'b0011 << {addr[1], 1'b0};
                wdata = {2{rs2v[15:0]}};
            end
            default: begin
                strb  = 4'b1111;
                wdata = rs2v;
            end
        endcase
        case (kind)
            tqv_pkg::ALU_IMM, tqv_pkg::ALU_REG: ;
            tqv_pkg::LUI:   res = imm;
            tqv_pkg::AUIPC: res = a + imm;
            tqv_pkg::JAL, tqv_pkg::JALR: begin
                res    = {8'h00, cur_pc + 24'd4};  // Link value
                exp_br = 1'b1;
                target = 24'(a + imm);
            end
            tqv_pkg::BRANCH: begin
                writes = 1'b0;
                exp_br = branch_taken(f3, a, b);
                target = cur_pc + imm[`TQV_PC_BITS-1:0];
                want   = 1;
            end
            tqv_pkg::LOAD:  res = load_expect(f3, addr);
            tqv_pkg::STORE: writes = 1'b0;
            default: begin
                writes = 1'b0;
                want   = 1;
            end
        endcase

        @(posedge clk);
        instr <= d;
        clocks = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            clocks++;
            if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
                check_value("paddr", 32'(apb_req.paddr), 32'(addr[`TQV_ADDR_BITS-1:0]));
                check_value("pwrite", 32'(apb_req.pwrite), 32'(kind == tqv_pkg::STORE));
                if (kind == tqv_pkg::STORE) begin
                    check_value("pstrb", 32'(apb_req.pstrb), 32'(strb));
                    check_value("pwdata", apb_req.pwdata & lane_mask(strb),
                                wdata & lane_mask(strb));
                end
            end
            if (instr_complete)
                finished = 1'b1;
            else
                check_value("branch", 32'(branch), 32'd0);
        end
        check_value("branch", 32'(branch), 32'(exp_br));
        if (exp_br || kind == tqv_pkg::BRANCH)
            check_value("branch_addr", 32'(branch_addr), 32'(target));
        if (is_mem) begin
            assert (clocks >= 4) else note_failure("memory access completed in under 4 clocks");
        end else begin
            check_value("completion clocks", clocks, want);
        end

        if (writes && rd != 0) ref_regs[rd] = res;
        if (kind == tqv_pkg::STORE) begin
            for (int k = 0; k < 4; k++)
                if (strb[k]) ref_mem[addr[7:2]][8*k +: 8] = wdata[8*k +: 8];
        end
        cur_pc = cur_pc + 24'd4;
    endtask

    task automatic store_word(input int rs2);
        exec(tqv_pkg::STORE, tqv_pkg::ALU_ADD, 3'b010, 7, rs2, 0, 32'h0);  // To 0x80
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("Test %0d (%s) done with %0d errors", tests_run, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic alu_and_shift_ops;
        exec(tqv_pkg::LUI, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 1, 32'h8765_4000);
        exec(tqv_pkg::ALU_IMM, tqv_pkg::ALU_ADD, 3'b000, 1, 0, 2, 32'h0000_0321);
        exec(tqv_pkg::ALU_IMM, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 5, 32'h0000_07EC);  // Positive
        exec(tqv_pkg::ALU_IMM, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 7, 32'h0000_0080);
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 10; k++) begin
                exec(tqv_pkg::ALU_REG, ops[k], 3'b000, p ? 5 : 2, p ? 2 : 5, 6, 32'h0);
                store_word(6);
            end
        end
        for (int k = 0; k < 10; k++) begin
            if (ops[k] != tqv_pkg::ALU_SUB) begin
                exec(tqv_pkg::ALU_IMM, ops[k], 3'b000, 2, 0, 6, 32'hFFFF_F9A3);
                store_word(6);
            end
        end
        exec(tqv_pkg::AUIPC, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 6, 32'h0001_2000);
        store_word(6);
    endtask

    task automatic completion_timing;
        exec(tqv_pkg::NOP, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 0, 32'h0);
        exec(tqv_pkg::SYSTEM, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 0, 32'h0);
        exec(tqv_pkg::LUI, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 3, 32'h5555_A000);
        exec(tqv_pkg::BRANCH, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 0, 32'h0000_0008);
        exec(tqv_pkg::LOAD, tqv_pkg::ALU_ADD, 3'b010, 7, 0, 3, 32'h0000_0004);
        store_word(3);
    endtask

    task automatic sub_word_stores;
        for (int lane = 0; lane < 4; lane++) begin
            exec(tqv_pkg::STORE, tqv_pkg::ALU_ADD, 3'b000, 7, 2, 0, 32'h10 + 5 * lane);
            exec(tqv_pkg::LOAD, tqv_pkg::ALU_ADD, 3'b010, 7, 0, 9, 32'h10 + 4 * lane);
            store_word(9);
        end
        for (int h = 0; h < 2; h++) begin
            exec(tqv_pkg::STORE, tqv_pkg::ALU_ADD, 3'b001, 7, 5, 0, 32'h20 + 6 * h);
            exec(tqv_pkg::LOAD, tqv_pkg::ALU_ADD, 3'b010, 7, 0, 9, 32'h20 + 4 * h);
            store_word(9);
        end
    endtask

    task automatic lane_loads;
        exec(tqv_pkg::ALU_IMM, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 8, 32'h0000_0040);
        for (int lane = 0; lane < 4; lane++) begin
            for (int u = 0; u < 2; u++) begin
                exec(tqv_pkg::LOAD, tqv_pkg::ALU_ADD, u ? 3'b100 : 3'b000, 8, 0, 9, 5 * lane);
                store_word(9);
                if (lane % 2 == 0) begin
                    exec(tqv_pkg::LOAD, tqv_pkg::ALU_ADD, u ? 3'b101 : 3'b001, 8, 0, 9,
                         32'h10 + 5 * lane);
                    store_word(9);
                end
            end
        end
        exec(tqv_pkg::LOAD, tqv_pkg::ALU_ADD, 3'b010, 8, 0, 9, 32'h0000_0020);
        store_word(9);
        exec(tqv_pkg::LOAD, tqv_pkg::ALU_ADD, 3'b010, 8, 0, 0, 32'h0);  // Into x0
        store_word(0);
        exec(tqv_pkg::ALU_IMM, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 0, 32'h0000_0005);
        store_word(0);
    endtask

    task automatic branches_and_jumps;
        logic [2:0] f3s [6];
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int c = 0; c < 6; c++) begin
            exec(tqv_pkg::BRANCH, tqv_pkg::ALU_ADD, f3s[c], 2, 5, 0, 32'h0000_0040);
            exec(tqv_pkg::BRANCH, tqv_pkg::ALU_ADD, f3s[c], 5, 2, 0, 32'hFFFF_FFF0);
            exec(tqv_pkg::BRANCH, tqv_pkg::ALU_ADD, f3s[c], 2, 2, 0, 32'h0000_0104);
        end
        exec(tqv_pkg::JAL, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 10, 32'h0000_0200);
        store_word(10);
        exec(tqv_pkg::JALR, tqv_pkg::ALU_ADD, 3'b000, 7, 0, 11, 32'h0000_0014);
        store_word(11);
        exec(tqv_pkg::NOP, tqv_pkg::ALU_ADD, 3'b000, 0, 0, 0, 32'h0);
    endtask

    // APB slave, roughly one wait state in four access cycles
    always @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 64; i++)
                mem[i] <= fill_word(i);
            apb_rsp <= '0;
        end else begin
            if (apb_req.psel && !(apb_req.penable && apb_rsp.pready)) begin
                apb_rsp.pready <= ($urandom % 4) != 0;
                apb_rsp.prdata <= mem[apb_req.paddr[7:2]];
            end else begin
                apb_rsp.pready <= 1'b0;
            end
            if (apb_req.psel && apb_req.penable && apb_rsp.pready && apb_req.pwrite) begin
                for (int k = 0; k < 4; k++)
                    if (apb_req.pstrb[k])
                        mem[apb_req.paddr[7:2]][8*k +: 8] <= apb_req.pwdata[8*k +: 8];
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rstn |=> !apb_req.psel && !apb_req.penable)
        else note_failure("APB select or enable high after reset");
    a_enable_needs_sel: assert property (@(posedge clk) disable iff (!rstn)
        apb_req.penable |-> apb_req.psel)
        else note_failure("penable high without psel");
    a_setup_then_access: assert property (@(posedge clk) disable iff (!rstn)
        apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
        else note_failure("APB SETUP not followed by ACCESS");
    a_hold_on_wait: assert property (@(posedge clk) disable iff (!rstn)
        apb_req.psel && apb_req.penable && !apb_rsp.pready |=> apb_req.psel &&
        apb_req.penable && $stable(apb_req.paddr) && $stable(apb_req.pwrite) &&
        $stable(apb_req.pwdata) && $stable(apb_req.pstrb))
        else note_failure("APB request changed during a wait state");
    a_idle_after_transfer: assert property (@(posedge clk) disable iff (!rstn)
        apb_req.psel && apb_req.penable && apb_rsp.pready |=> !apb_req.psel && instr_complete)
        else note_failure("no idle cycle or no completion after the APB transfer");
    a_mem_complete_late: assert property (@(posedge clk) disable iff (!rstn)
        instr_complete && (instr.kind == tqv_pkg::LOAD || instr.kind == tqv_pkg::STORE) |->
        $past(apb_req.psel && apb_req.penable && apb_rsp.pready))
        else note_failure("memory instruction completed without a finished APB transfer");

    initial begin
        void'($urandom(9));
        rstn = 1'b0;
        instr = '0;
        cur_pc = 24'h001000;
        for (int i = 0; i < `TQV_NUM_REGS; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < 64; i++)
            ref_mem[i] = fill_word(i);
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        alu_and_shift_ops();
        end_test("ALU and shifter");
        completion_timing();
        end_test("completion timing");
        sub_word_stores();
        end_test("sub-word stores");
        lane_loads();
        end_test("loads");
        branches_and_jumps();
        end_test("branches and jumps");

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
tqv_pkg.sv
tqv_alu.sv
tqv_shifter.sv
tqv_registers.sv
tqv_lsu_apb.sv
tqv_core.sv
tqv_exec_top.sv
tb_tqv_exec.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_tqv_exec -f filelist.f
./obj_dir/Vtb_tqv_exec | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
exit 1
